//--- execute_unit.f
rtl/alu_pkg.sv
rtl/alu.sv
rtl/shift_unit.sv
rtl/ex_result_stage.sv
rtl/execute_unit.sv
tb/execute_unit_sva.sv
tb/tb_execute_unit.sv

//--- rtl/alu.sv
/*
 * Combinational arithmetic and logic unit.
 * DATA_WIDTH must be 33 or more, since word operations use the low 32 bits.
 * Carry and overflow are meaningful for ADD and SUB only and read 0 otherwise.
 * Shift operations return zero here; the shift unit owns them.
 */

`timescale 1ns/10ps

module alu #(
    parameter int DATA_WIDTH = 64
) (
    input  alu_pkg::t_alu_op        i_alu_op,
    input  logic [DATA_WIDTH - 1:0] i_src_1,
    input  logic [DATA_WIDTH - 1:0] i_src_2,
    output logic [DATA_WIDTH - 1:0] o_alu_result,
    output logic                    o_carry_flag,
    output logic                    o_overflow_flag
);

    typedef logic [DATA_WIDTH - 1:0] t_data;
    typedef logic [31:0]             t_word;

    localparam int MSB = DATA_WIDTH - 1;

    // ------------------------------------------------------------
    // Shared adder and subtractor.
    // ------------------------------------------------------------
    t_data s_sum;
    t_data s_diff;
    logic  s_carry;
    logic  s_borrow;
    logic  s_add_ovf;
    logic  s_sub_ovf;
    logic  s_less_signed;

    // Extra top bit gives carry out of the sum and borrow of the difference.
    assign {s_carry, s_sum}   = {1'b0, i_src_1} + {1'b0, i_src_2};
    assign {s_borrow, s_diff} = {1'b0, i_src_1} - {1'b0, i_src_2};

    // Signed overflow from the operand and result signs.
    assign s_add_ovf = ~(i_src_1[MSB] ^ i_src_2[MSB]) & (s_sum[MSB] ^ i_src_1[MSB]);
    assign s_sub_ovf = (i_src_1[MSB] ^ i_src_2[MSB]) & (s_diff[MSB] ^ i_src_1[MSB]);

    // Signed compare, corrected for overflow of the difference.
    assign s_less_signed = s_diff[MSB] ^ s_sub_ovf;

    // ------------------------------------------------------------
    // Word add and subtract.
    // ------------------------------------------------------------
    t_word s_sum_w;
    t_word s_diff_w;
    t_data s_sum_w_ext;
    t_data s_diff_w_ext;

    assign s_sum_w  = i_src_1[31:0] + i_src_2[31:0];
    assign s_diff_w = i_src_1[31:0] - i_src_2[31:0];

    assign s_sum_w_ext  = {{(DATA_WIDTH - 32){s_sum_w[31]}}, s_sum_w};
    assign s_diff_w_ext = {{(DATA_WIDTH - 32){s_diff_w[31]}}, s_diff_w};

    // ------------------------------------------------------------
    // Output select.
    // ------------------------------------------------------------
    always_comb begin
        o_alu_result    = '0;
        o_carry_flag    = 1'b0;
        o_overflow_flag = 1'b0;

        case (i_alu_op)
            alu_pkg::ADD: begin
                o_alu_result    = s_sum;
                o_carry_flag    = s_carry;
                o_overflow_flag = s_add_ovf;
            end
            alu_pkg::SUB: begin
                o_alu_result    = s_diff;
                o_carry_flag    = s_borrow;
                o_overflow_flag = s_sub_ovf;
            end
            alu_pkg::AND:  o_alu_result = i_src_1 & i_src_2;
            alu_pkg::OR:   o_alu_result = i_src_1 | i_src_2;
            alu_pkg::XOR:  o_alu_result = i_src_1 ^ i_src_2;
            alu_pkg::SLT:  o_alu_result = {{(DATA_WIDTH - 1){1'b0}}, s_less_signed};
            alu_pkg::SLTU: o_alu_result = {{(DATA_WIDTH - 1){1'b0}}, s_borrow};
            alu_pkg::SUBU: o_alu_result = s_diff;
            alu_pkg::ADDW: o_alu_result = s_sum_w_ext;
            alu_pkg::SUBW: o_alu_result = s_diff_w_ext;
            // Shifts belong to the shift unit.
            default:       o_alu_result = '0;
        endcase
    end

endmodule

//--- rtl/alu_pkg.sv
/*
 * Operation codes shared by the integer execute stage.
 * The encoding is fixed at four bits and matches the decoder's control field.
 * Data width is not defined here; every module takes it as a parameter.
 */

package alu_pkg;

    // ------------------------------------------------------------
    // Operation code.
    // ------------------------------------------------------------
    localparam int ALU_OP_WIDTH = 4;

    typedef enum logic [ALU_OP_WIDTH - 1:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SLT  = 4'd6,
        SLTU = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9,
        SUBU = 4'd10,
        ADDW = 4'd11,
        SUBW = 4'd12,
        SLLW = 4'd13,
        SRLW = 4'd14,
        SRAW = 4'd15
    } t_alu_op;

endpackage

//--- rtl/ex_result_stage.sv
/*
 * Result stage of the execute unit.
 * Picks the shift or ALU result by operation, forms zero and negative flags,
 * and registers result and flags on a valid input. Latency is one cycle.
 * Outputs hold their last value while o_valid is low. No back-pressure.
 */

`timescale 1ns/10ps

module ex_result_stage #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_valid,
    input  alu_pkg::t_alu_op        i_alu_op,
    input  logic [DATA_WIDTH - 1:0] i_alu_result,
    input  logic                    i_alu_carry,
    input  logic                    i_alu_overflow,
    input  logic [DATA_WIDTH - 1:0] i_shift_result,
    output logic                    o_valid,
    output logic [DATA_WIDTH - 1:0] o_result,
    output logic                    o_zero_flag,
    output logic                    o_negative_flag,
    output logic                    o_carry_flag,
    output logic                    o_overflow_flag
);

    typedef logic [DATA_WIDTH - 1:0] t_data;

    logic  s_is_shift;
    t_data s_result;
    logic  s_zero;
    logic  s_negative;

    // ------------------------------------------------------------
    // Unit select and flags.
    // ------------------------------------------------------------
    always_comb begin
        case (i_alu_op)
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA,
            alu_pkg::SLLW, alu_pkg::SRLW, alu_pkg::SRAW: s_is_shift = 1'b1;
            default:                                     s_is_shift = 1'b0;
        endcase
    end

    assign s_result   = s_is_shift ? i_shift_result : i_alu_result;
    assign s_zero     = (s_result == '0);
    assign s_negative = s_result[DATA_WIDTH - 1];

    // ------------------------------------------------------------
    // Output registers.
    // ------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid         <= 1'b0;
            o_result        <= '0;
            o_zero_flag     <= 1'b0;
            o_negative_flag <= 1'b0;
            o_carry_flag    <= 1'b0;
            o_overflow_flag <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_result        <= s_result;
                o_zero_flag     <= s_zero;
                o_negative_flag <= s_negative;
                // ALU already drives 0 for shifts.
                o_carry_flag    <= i_alu_carry;
                o_overflow_flag <= i_alu_overflow;
            end
        end
    end

endmodule

//--- rtl/execute_unit.sv
/*
 * Integer execute stage, top level.
 * ALU and shift unit run in parallel on the same operands; the result stage
 * registers the owning unit's output one cycle after i_valid.
 * DATA_WIDTH must be a power of two and 33 or more.
 */

`timescale 1ns/10ps

module execute_unit #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_valid,
    input  alu_pkg::t_alu_op        i_alu_op,
    input  logic [DATA_WIDTH - 1:0] i_src_1,
    input  logic [DATA_WIDTH - 1:0] i_src_2,
    output logic                    o_valid,
    output logic [DATA_WIDTH - 1:0] o_result,
    output logic                    o_zero_flag,
    output logic                    o_negative_flag,
    output logic                    o_carry_flag,
    output logic                    o_overflow_flag
);

    logic [DATA_WIDTH - 1:0] alu_result;
    logic                    alu_carry;
    logic                    alu_overflow;
    logic [DATA_WIDTH - 1:0] shift_result;

    // ------------------------------------------------------------
    // Functional units.
    // ------------------------------------------------------------
    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu (
        .i_alu_op        (i_alu_op),
        .i_src_1         (i_src_1),
        .i_src_2         (i_src_2),
        .o_alu_result    (alu_result),
        .o_carry_flag    (alu_carry),
        .o_overflow_flag (alu_overflow)
    );

    shift_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_shift_unit (
        .i_alu_op       (i_alu_op),
        .i_src_1        (i_src_1),
        .i_src_2        (i_src_2),
        .o_shift_result (shift_result)
    );

    // Registered output.
    ex_result_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ex_result_stage (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_alu_op        (i_alu_op),
        .i_alu_result    (alu_result),
        .i_alu_carry     (alu_carry),
        .i_alu_overflow  (alu_overflow),
        .i_shift_result  (shift_result),
        .o_valid         (o_valid),
        .o_result        (o_result),
        .o_zero_flag     (o_zero_flag),
        .o_negative_flag (o_negative_flag),
        .o_carry_flag    (o_carry_flag),
        .o_overflow_flag (o_overflow_flag)
    );

endmodule

//--- rtl/shift_unit.sv
/*
 * Combinational shifter for full-width and word shifts.
 * Full-width shifts use the low log2(DATA_WIDTH) bits of src_2 as amount.
 * Word shifts use the low 5 bits and sign-extend the 32-bit result.
 * DATA_WIDTH must be a power of two and 33 or more.
 */

`timescale 1ns/10ps

module shift_unit #(
    parameter int DATA_WIDTH = 64
) (
    input  alu_pkg::t_alu_op        i_alu_op,
    input  logic [DATA_WIDTH - 1:0] i_src_1,
    input  logic [DATA_WIDTH - 1:0] i_src_2,
    output logic [DATA_WIDTH - 1:0] o_shift_result
);

    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

    typedef logic [SHAMT_WIDTH - 1:0] t_shamt;
    typedef logic [4:0]               t_shamt_w;
    typedef logic [31:0]              t_word;

    t_shamt   s_shamt;
    t_shamt_w s_shamt_w;
    t_word    s_src_w;
    t_word    s_word_out;

    // Amount bits above the used range are ignored.
    assign s_shamt   = i_src_2[SHAMT_WIDTH - 1:0];
    assign s_shamt_w = i_src_2[4:0];
    assign s_src_w   = i_src_1[31:0];

    // ------------------------------------------------------------
    // Word shifter.
    // ------------------------------------------------------------
    always_comb begin
        case (i_alu_op)
            alu_pkg::SLLW: s_word_out = s_src_w << s_shamt_w;
            alu_pkg::SRLW: s_word_out = s_src_w >> s_shamt_w;
            alu_pkg::SRAW: s_word_out = $signed(s_src_w) >>> s_shamt_w;
            default:       s_word_out = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Output select.
    // ------------------------------------------------------------
    always_comb begin
        case (i_alu_op)
            alu_pkg::SLL:  o_shift_result = i_src_1 << s_shamt;
            alu_pkg::SRL:  o_shift_result = i_src_1 >> s_shamt;
            alu_pkg::SRA:  o_shift_result = $signed(i_src_1) >>> s_shamt;
            alu_pkg::SLLW,
            alu_pkg::SRLW,
            alu_pkg::SRAW: o_shift_result = {{(DATA_WIDTH - 32){s_word_out[31]}}, s_word_out};
            default:       o_shift_result = '0;
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the execute unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_execute_unit -f execute_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_execute_unit)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- tb/execute_unit_sva.sv
/*
 * Assertions on the execute unit outputs, bound into every instance.
 * Valid timing assumes a latency of one cycle and no back-pressure.
 * Flag checks apply only on cycles where o_valid is high.
 */

`timescale 1ns/10ps

module execute_unit_sva #(
    parameter int DATA_WIDTH = 64
) (
    input logic                    i_clk,
    input logic                    i_arst_n,
    input logic                    i_valid,
    input logic                    o_valid,
    input logic [DATA_WIDTH - 1:0] o_result,
    input logic                    o_zero_flag,
    input logic                    o_negative_flag
);

    // ------------------------------------------------------------
    // Valid timing.
    // ------------------------------------------------------------
    a_valid_follows_input: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |=> o_valid)
        else $error("o_valid did not follow i_valid after one cycle");

    a_valid_only_after_input: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !i_valid |=> !o_valid)
        else $error("o_valid rose without a preceding i_valid");

    a_valid_low_in_reset: assert property (@(posedge i_clk)
        !i_arst_n |-> !o_valid)
        else $error("o_valid high while reset is applied");

    // ------------------------------------------------------------
    // Flag consistency.
    // ------------------------------------------------------------
    a_zero_flag: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid |-> (o_zero_flag == (o_result == '0)))
        else $error("o_zero_flag disagrees with o_result");

    a_negative_flag: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid |-> (o_negative_flag == o_result[DATA_WIDTH - 1]))
        else $error("o_negative_flag disagrees with o_result");

endmodule

bind execute_unit execute_unit_sva #(
    .DATA_WIDTH (DATA_WIDTH)
) u_execute_unit_sva (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_valid         (i_valid),
    .o_valid         (o_valid),
    .o_result        (o_result),
    .o_zero_flag     (o_zero_flag),
    .o_negative_flag (o_negative_flag)
);

//--- tb/tb_execute_unit.sv
/*
 * Testbench for the execute unit at DATA_WIDTH 64.
 * Inputs change on the falling edge; outputs are compared at the rising edge
 * against a reference model, in issue order, through an expectation queue.
 */

`timescale 1ns/10ps

module tb_execute_unit;

    localparam int DATA_WIDTH     = 64;
    localparam int MSB            = DATA_WIDTH - 1;
    localparam int PERIOD         = 40;
    localparam int RESET_CYCLES   = 4;
    localparam int N_DIRECTED     = 100;
    localparam int N_STREAM       = 400;
    localparam int MAX_GAP        = 3;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * N_DIRECTED
                                  + N_STREAM * (MAX_GAP + 1) + 50;

    typedef logic [DATA_WIDTH - 1:0] t_data;
    typedef struct packed {
        t_data result;
        logic  zero;
        logic  negative;
        logic  carry;
        logic  overflow;
    } t_expect;

    localparam t_data ZERO     = '0;
    localparam t_data ONE      = 64'd1;
    localparam t_data ALL_ONES = '1;
    localparam t_data MAX_POS  = {1'b0, {MSB{1'b1}}};
    localparam t_data MIN_NEG  = {1'b1, {MSB{1'b0}}};

    logic             i_clk;
    logic             i_arst_n;
    logic             i_valid;
    alu_pkg::t_alu_op i_alu_op;
    t_data            i_src_1;
    t_data            i_src_2;
    logic             o_valid;
    t_data            o_result;
    logic             o_zero_flag;
    logic             o_negative_flag;
    logic             o_carry_flag;
    logic             o_overflow_flag;

    t_expect expect_q[$];
    // Last result, which the outputs hold between valid cycles.
    t_expect held = '0;
    int      errors = 0;
    int      checks = 0;
    int      issued = 0;
    bit      reset_checked = 1'b0;

    execute_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_execute_unit (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_alu_op        (i_alu_op),
        .i_src_1         (i_src_1),
        .i_src_2         (i_src_2),
        .o_valid         (o_valid),
        .o_result        (o_result),
        .o_zero_flag     (o_zero_flag),
        .o_negative_flag (o_negative_flag),
        .o_carry_flag    (o_carry_flag),
        .o_overflow_flag (o_overflow_flag)
    );

    initial begin
        i_clk = 1'b0;
        forever #(PERIOD / 2) i_clk = ~i_clk;
    end

    // ------------------------------------------------------------
    // Reference model.
    // ------------------------------------------------------------
    function automatic t_expect reference_model(alu_pkg::t_alu_op op, t_data a, t_data b);
        t_expect     e;
        logic [64:0] wide;
        logic [31:0] word;
        logic [5:0]  n;
        logic [4:0]  nw;
        e    = '0;
        word = '0;
        n    = b[5:0];
        nw   = b[4:0];
        case (op)
            alu_pkg::ADD: begin
                wide       = {1'b0, a} + {1'b0, b};
                e.result   = wide[MSB:0];
                e.carry    = wide[DATA_WIDTH];
                e.overflow = (a[MSB] == b[MSB]) && (e.result[MSB] != a[MSB]);
            end
            alu_pkg::SUB: begin
                e.result   = a - b;
                e.carry    = (a < b);
                e.overflow = (a[MSB] != b[MSB]) && (e.result[MSB] != a[MSB]);
            end
            alu_pkg::AND:  e.result = a & b;
            alu_pkg::OR:   e.result = a | b;
            alu_pkg::XOR:  e.result = a ^ b;
            alu_pkg::SLT:  e.result = ($signed(a) < $signed(b)) ? ONE : ZERO;
            alu_pkg::SLTU: e.result = (a < b) ? ONE : ZERO;
            alu_pkg::SUBU: e.result = a - b;
            alu_pkg::SLL:  e.result = a << n;
            alu_pkg::SRL:  e.result = a >> n;
            // Arithmetic shift as logical shift plus sign fill.
            alu_pkg::SRA:  e.result = (a >> n) | (a[MSB] ? ~(ALL_ONES >> n) : ZERO);
            alu_pkg::ADDW: word = a[31:0] + b[31:0];
            alu_pkg::SUBW: word = a[31:0] - b[31:0];
            alu_pkg::SLLW: word = a[31:0] << nw;
            alu_pkg::SRLW: word = a[31:0] >> nw;
            alu_pkg::SRAW: word = (a[31:0] >> nw) | (a[31] ? ~(32'hffff_ffff >> nw) : 32'h0);
            default:       e.result = ZERO;
        endcase
        if (op inside {alu_pkg::ADDW, alu_pkg::SUBW, alu_pkg::SLLW, alu_pkg::SRLW,
                       alu_pkg::SRAW}) begin
            e.result = {{(DATA_WIDTH - 32){word[31]}}, word};
        end
        e.zero     = (e.result == ZERO);
        e.negative = e.result[MSB];
        return e;
    endfunction

    task automatic check_value(input string name, input t_data expected, input t_data actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Result and all four flags against one expectation.
    task automatic verify_outputs(input t_expect e);
        check_value("o_result", e.result, o_result);
        check_value("o_zero_flag", t_data'(e.zero), t_data'(o_zero_flag));
        check_value("o_negative_flag", t_data'(e.negative), t_data'(o_negative_flag));
        check_value("o_carry_flag", t_data'(e.carry), t_data'(o_carry_flag));
        check_value("o_overflow_flag", t_data'(e.overflow), t_data'(o_overflow_flag));
    endtask

    // ------------------------------------------------------------
    // Compare process.
    // ------------------------------------------------------------
    always @(posedge i_clk) begin : compare_outputs
        t_expect expected;
        if (i_arst_n === 1'b1 && !reset_checked) begin
            // First edge after reset with nothing issued yet.
            reset_checked = 1'b1;
            check_value("o_valid", ZERO, t_data'(o_valid));
            verify_outputs(held);
        end else if (i_arst_n === 1'b1 && o_valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("Unexpected o_valid at %0t with no operation pending", $time);
            end else begin
                expected = expect_q.pop_front();
                verify_outputs(expected);
                held = expected;
            end
        end else if (i_arst_n === 1'b1) begin
            // Outputs keep the last result while o_valid is low.
            verify_outputs(held);
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers.
    // ------------------------------------------------------------
    function automatic t_data random_data();
        return {$urandom, $urandom};
    endfunction

    function automatic alu_pkg::t_alu_op random_op();
        logic [3:0] code;
        code = 4'($urandom_range(15, 0));
        return alu_pkg::t_alu_op'(code);
    endfunction

    task automatic issue_op(input alu_pkg::t_alu_op op, input t_data a, input t_data b);
        @(negedge i_clk);
        i_valid  = 1'b1;
        i_alu_op = op;
        i_src_1  = a;
        i_src_2  = b;
        expect_q.push_back(reference_model(op, a, b));
        issued++;
    endtask

    // Operation and operands change freely while i_valid is low.
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            i_valid  = 1'b0;
            i_alu_op = random_op();
            i_src_1  = random_data();
            i_src_2  = random_data();
        end
    endtask

    // One valid pulse followed by an idle cycle.
    task automatic single_op(input alu_pkg::t_alu_op op, input t_data a, input t_data b);
        issue_op(op, a, b);
        idle(1);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------
    initial begin
        t_data            x;
        t_data            y;
        alu_pkg::t_alu_op logic_ops[6] = '{alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR,
                                           alu_pkg::SLT, alu_pkg::SLTU, alu_pkg::SUBU};
        alu_pkg::t_alu_op shift_ops[3] = '{alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA};
        alu_pkg::t_alu_op word_ops[3]  = '{alu_pkg::SLLW, alu_pkg::SRLW, alu_pkg::SRAW};
        void'($urandom(32'h451a_48bc));
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_alu_op = alu_pkg::ADD;
        i_src_1  = ZERO;
        i_src_2  = ZERO;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_arst_n = 1'b1;

        // Sign and carry boundaries.
        single_op(alu_pkg::ADD, MAX_POS, ONE);
        single_op(alu_pkg::ADD, ALL_ONES, ONE);
        single_op(alu_pkg::ADD, MIN_NEG, MIN_NEG);
        single_op(alu_pkg::ADD, MAX_POS, MAX_POS);
        single_op(alu_pkg::SUB, ZERO, ONE);
        single_op(alu_pkg::SUB, MIN_NEG, ONE);
        single_op(alu_pkg::SUB, MAX_POS, ALL_ONES);
        single_op(alu_pkg::SUB, ONE, ONE);

        // Logic and compare, with equal and mixed-sign pairs.
        foreach (logic_ops[i]) begin
            x = random_data();
            single_op(logic_ops[i], x, x);
            single_op(logic_ops[i], x | MIN_NEG, x & MAX_POS);
            single_op(logic_ops[i], x & MAX_POS, x | MIN_NEG);
            repeat (4) single_op(logic_ops[i], random_data(), random_data());
        end

        foreach (shift_ops[i]) begin
            x = random_data();
            y = random_data();
            single_op(shift_ops[i], x | MIN_NEG, ZERO);
            single_op(shift_ops[i], x | MIN_NEG, ONE);
            single_op(shift_ops[i], x | MIN_NEG, 64'd63);
            single_op(shift_ops[i], x, {y[63:6], 6'd63});
            repeat (3) single_op(shift_ops[i], random_data(), random_data());
        end
        foreach (word_ops[i]) begin
            single_op(word_ops[i], random_data() | 64'h8000_0000, random_data());
            repeat (4) single_op(word_ops[i], random_data(), random_data());
        end

        // Word add and subtract crossing 32 bits.
        x = random_data();
        y = random_data();
        single_op(alu_pkg::ADDW, {x[63:32], 32'h7fff_ffff}, {y[63:32], 32'h0000_0001});
        single_op(alu_pkg::ADDW, {x[63:32], 32'hffff_ffff}, ONE);
        single_op(alu_pkg::SUBW, {x[63:32], 32'h8000_0000}, {y[63:32], 32'h0000_0001});
        single_op(alu_pkg::SUBW, ZERO, ONE);

        // Random stream with random gaps.
        repeat (N_STREAM) begin
            issue_op(random_op(), random_data(), random_data());
            idle($urandom_range(MAX_GAP, 0));
        end
        idle(3);

        if (expect_q.size() != 0) begin
            $display("%0d operations issued but never returned a result", expect_q.size());
        end
        $display("Operations: %0d, checks: %0d, errors: %0d", issued, checks, errors);
        if (errors == 0 && expect_q.size() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
